/* logic/mac_defines.svh */
//////////////////////////////////////////////////////////////////////
// Project-wide widths for the vector multiply-accumulate unit.
// Include this in any file that sizes vector, scalar or tag signals.
//////////////////////////////////////////////////////////////////////

`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

`define MAC_VLEN    128                 // vector register width
`define MAC_XLEN    32                  // scalar operand width
`define MAC_ROB_W   5                   // reorder-buffer tag width
`define MAC_PROD_W  (2*`MAC_VLEN)       // full products, all elements

// elements per vector register at each element width
`define MAC_NE8     (`MAC_VLEN/8)
`define MAC_NE16    (`MAC_VLEN/16)
`define MAC_NE32    (`MAC_VLEN/32)

`endif

/* logic/mac_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the vector multiply-accumulate unit.
// Imported by wildcard in the header of every module that needs them.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mac_pkg;

    typedef enum logic [2:0] {
        EEW8  = 3'b000,
        EEW16 = 3'b001,
        EEW32 = 3'b010
    } eew_e;

    // RVV instruction categories
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVX = 3'b100,
        OPMVX = 3'b110
    } funct3_e;

    // vsmul and vmulh share one code in different categories
    typedef logic [5:0] funct6_e;

    localparam funct6_e VMULHU  = 6'b100100;
    localparam funct6_e VMUL    = 6'b100101;
    localparam funct6_e VMULHSU = 6'b100110;
    localparam funct6_e VMULH   = 6'b100111;
    localparam funct6_e VSMUL   = 6'b100111;   // OPIVV / OPIVX
    localparam funct6_e VMADD   = 6'b101001;
    localparam funct6_e VNMSUB  = 6'b101011;
    localparam funct6_e VMACC   = 6'b101101;
    localparam funct6_e VNMSAC  = 6'b101111;

    // fixed-point rounding
    typedef enum logic [1:0] {
        RNU = 2'd0,   // round to nearest up
        RNE = 2'd1,   // round to nearest even
        RDN = 2'd2,   // truncate
        ROD = 2'd3    // round to odd
    } vxrm_e;

endpackage

`default_nettype wire

/* logic/mac_issue_stage.sv */
//////////////////////////////////////////////////////////////////////
// First stage of the multiply-accumulate unit. Decodes the micro-op,
// routes and broadcasts operands to the multiplier array and
// registers the control and addend for the result stage.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mac_defines.svh"

module mac_issue_stage
    import mac_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  uop_valid,
    input  funct3_e               funct3,
    input  funct6_e               funct6,
    input  vxrm_e                 vxrm,
    input  eew_e                  eew,
    input  logic [`MAC_ROB_W-1:0] rob_entry,
    input  logic [`MAC_VLEN-1:0]  vs1_data,
    input  logic                  vs1_valid,
    input  logic [`MAC_VLEN-1:0]  vs2_data,
    input  logic                  vs2_valid,
    input  logic [`MAC_VLEN-1:0]  vs3_data,
    input  logic                  vs3_valid,
    input  logic [`MAC_XLEN-1:0]  rs1_data,
    input  logic                  rs1_valid,
    output logic [`MAC_VLEN-1:0]  src_a,
    output logic [`MAC_VLEN-1:0]  src_b,
    output logic                  a_signed,
    output logic                  b_signed,
    output eew_e                  mul_eew,
    output logic                  stage_valid,
    output logic [`MAC_VLEN-1:0]  addend,
    output logic                  keep_low,
    output logic                  mul_reverse,
    output logic                  is_vmac,
    output logic                  is_vsmul,
    output eew_e                  res_eew,
    output vxrm_e                 res_vxrm,
    output logic [`MAC_ROB_W-1:0] res_rob_entry
);

    logic                 op_valid;
    logic                 is_vv;
    logic                 swap_vd;       // multiplicand is vd
    logic                 dec_low;
    logic                 dec_reverse;
    logic                 dec_vmac;
    logic                 dec_vsmul;
    logic [`MAC_VLEN-1:0] vs1_m;
    logic [`MAC_VLEN-1:0] vs2_m;
    logic [`MAC_VLEN-1:0] vs3_m;
    logic [`MAC_XLEN-1:0] rs1_m;
    logic [`MAC_VLEN-1:0] scalar_bc;
    logic [`MAC_VLEN-1:0] addend_d;

    assign vs1_m = vs1_valid ? vs1_data : '0;
    assign vs2_m = vs2_valid ? vs2_data : '0;
    assign vs3_m = vs3_valid ? vs3_data : '0;
    assign rs1_m = rs1_valid ? rs1_data : '0;

    //////////////////////////////////////////////////////////////////////
    // decode
    always_comb begin
        op_valid    = 1'b0;
        is_vv       = 1'b1;
        swap_vd     = 1'b0;
        a_signed    = 1'b1;
        b_signed    = 1'b1;
        dec_low     = 1'b1;
        dec_reverse = 1'b0;
        dec_vmac    = 1'b0;
        dec_vsmul   = 1'b0;
        case (funct3)
            OPIVV, OPIVX: begin            // any funct6 runs as vsmul
                op_valid  = uop_valid;
                is_vv     = (funct3 == OPIVV);
                dec_low   = 1'b0;
                dec_vsmul = 1'b1;
            end
            OPMVV, OPMVX: begin
                op_valid = uop_valid;
                is_vv    = (funct3 == OPMVV);
                case (funct6)
                    VMUL:    dec_low = 1'b1;
                    VMULH:   dec_low = 1'b0;
                    VMULHU: begin
                        dec_low  = 1'b0;
                        a_signed = 1'b0;
                        b_signed = 1'b0;
                    end
                    VMULHSU: begin
                        dec_low  = 1'b0;
                        b_signed = 1'b0;
                    end
                    VMACC:   dec_vmac = 1'b1;
                    VNMSAC: begin
                        dec_vmac    = 1'b1;
                        dec_reverse = 1'b1;
                    end
                    VMADD: begin
                        dec_vmac = 1'b1;
                        swap_vd  = 1'b1;
                    end
                    VNMSUB: begin
                        dec_vmac    = 1'b1;
                        dec_reverse = 1'b1;
                        swap_vd     = 1'b1;
                    end
                    default: dec_low = 1'b1;    // plain vmul
                endcase
            end
            default: op_valid = 1'b0;
        endcase
    end

    // element width never exceeds XLEN, so the multiplier does the sign extension
    always_comb begin
        case (eew)
            EEW16:   scalar_bc = {`MAC_NE16{rs1_m[15:0]}};
            EEW32:   scalar_bc = {`MAC_NE32{rs1_m[31:0]}};
            default: scalar_bc = {`MAC_NE8{rs1_m[7:0]}};
        endcase
    end

    assign src_a    = op_valid ? (swap_vd ? vs3_m : vs2_m) : '0;
    assign src_b    = !op_valid ? '0 : (is_vv ? vs1_m : scalar_bc);
    assign addend_d = (op_valid && dec_vmac) ? (swap_vd ? vs2_m : vs3_m) : '0;
    assign mul_eew  = eew;

    //////////////////////////////////////////////////////////////////////
    // stage register, aligned with the product register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid   <= 1'b0;
            addend        <= '0;
            keep_low      <= 1'b0;
            mul_reverse   <= 1'b0;
            is_vmac       <= 1'b0;
            is_vsmul      <= 1'b0;
            res_eew       <= EEW8;
            res_vxrm      <= RNU;
            res_rob_entry <= '0;
        end else begin
            stage_valid   <= op_valid;
            addend        <= addend_d;
            keep_low      <= dec_low;
            mul_reverse   <= dec_reverse;
            is_vmac       <= dec_vmac;
            is_vsmul      <= dec_vsmul;
            res_eew       <= eew;
            res_vxrm      <= vxrm;
            res_rob_entry <= rob_entry;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_mul_array.sv */
//////////////////////////////////////////////////////////////////////
// Per-element multipliers of the multiply-accumulate unit. Every
// element is multiplied at the selected width into a double-width
// product, and the full products are registered.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mac_defines.svh"

module mac_mul_array
    import mac_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`MAC_VLEN-1:0]   src_a,
    input  logic [`MAC_VLEN-1:0]   src_b,
    input  logic                   a_signed,
    input  logic                   b_signed,
    input  eew_e                   mul_eew,
    output logic [`MAC_PROD_W-1:0] products
);

    wire  [`MAC_PROD_W-1:0] prod_w [3];    // 8, 16, 32 bit lanes
    logic [`MAC_PROD_W-1:0] prod_sel;

    for (genvar w = 0; w < 3; w++) begin : g_width
        localparam int EW = 8 << w;
        localparam int NE = `MAC_VLEN / EW;

        for (genvar e = 0; e < NE; e++) begin : g_elem
            wire [2*EW-1:0] a_ext;
            wire [2*EW-1:0] b_ext;

            assign a_ext = {{EW{a_signed & src_a[EW*e+EW-1]}}, src_a[EW*e +: EW]};
            assign b_ext = {{EW{b_signed & src_b[EW*e+EW-1]}}, src_b[EW*e +: EW]};
            assign prod_w[w][2*EW*e +: 2*EW] = a_ext * b_ext;   // mod 2^(2*EW)
        end
    end

    always_comb begin
        case (mul_eew)
            EEW16:   prod_sel = prod_w[1];
            EEW32:   prod_sel = prod_w[2];
            default: prod_sel = prod_w[0];
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            products <= '0;
        end else begin
            products <= prod_sel;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_result_stage.sv */
//////////////////////////////////////////////////////////////////////
// Result stage of the multiply-accumulate unit. Combinational. Picks
// the product half, accumulates, rounds and saturates vsmul, and
// forms the write-back outputs.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mac_defines.svh"

module mac_result_stage
    import mac_pkg::*;
(
    input  logic                   stage_valid,
    input  logic [`MAC_PROD_W-1:0] products,
    input  logic [`MAC_VLEN-1:0]   addend,
    input  logic                   keep_low,
    input  logic                   mul_reverse,
    input  logic                   is_vmac,
    input  logic                   is_vsmul,
    input  eew_e                   res_eew,
    input  vxrm_e                  res_vxrm,
    input  logic [`MAC_ROB_W-1:0]  res_rob_entry,
    output logic                   w_valid,
    output logic [`MAC_VLEN-1:0]   w_data,
    output logic                   vxsat,
    output logic [`MAC_ROB_W-1:0]  w_rob_entry
);

    wire  [`MAC_VLEN-1:0] data_w [3];
    wire  [2:0]           sat_w;
    logic [`MAC_VLEN-1:0] data_sel;
    logic                 sat_sel;

    for (genvar w = 0; w < 3; w++) begin : g_width
        localparam int EW = 8 << w;
        localparam int NE = `MAC_VLEN / EW;

        wire [NE-1:0] sat_e;

        for (genvar e = 0; e < NE; e++) begin : g_elem
            wire  [2*EW-1:0] prod;
            wire  [EW-1:0]   half;
            wire  [EW-1:0]   acc;
            wire  [EW-1:0]   rnd;
            wire             lsb;
            wire             rbit;
            wire             sticky;
            logic            incr;

            assign prod = products[2*EW*e +: 2*EW];
            assign half = keep_low ? prod[EW-1:0] : prod[2*EW-1:EW];
            assign acc  = mul_reverse ? addend[EW*e +: EW] - half
                                      : addend[EW*e +: EW] + half;

            // vsmul keeps prod >> (EW-1)
            assign lsb    = prod[EW-1];
            assign rbit   = prod[EW-2];
            assign sticky = |prod[EW-3:0];

            always_comb begin
                case (res_vxrm)
                    RNU:     incr = rbit;
                    RNE:     incr = rbit & (sticky | lsb);
                    RDN:     incr = 1'b0;
                    default: incr = ~lsb & (rbit | sticky);   // rod
                endcase
            end

            assign rnd      = prod[EW-1 +: EW] + EW'(incr);
            assign sat_e[e] = (prod[2*EW-1 -: 2] == 2'b01);   // only -min * -min

            assign data_w[w][EW*e +: EW] =
                is_vmac  ? acc :
                is_vsmul ? (sat_e[e] ? {1'b0, {(EW-1){1'b1}}} : rnd) :
                           half;
        end

        assign sat_w[w] = |sat_e;
    end

    always_comb begin
        case (res_eew)
            EEW16: begin
                data_sel = data_w[1];
                sat_sel  = sat_w[1];
            end
            EEW32: begin
                data_sel = data_w[2];
                sat_sel  = sat_w[2];
            end
            default: begin
                data_sel = data_w[0];
                sat_sel  = sat_w[0];
            end
        endcase
    end

    assign w_valid     = stage_valid;
    assign w_data      = stage_valid ? data_sel : '0;
    assign vxsat       = stage_valid & is_vsmul & sat_sel;
    assign w_rob_entry = res_rob_entry;

endmodule

`default_nettype wire

/* logic/mac_unit.sv */
//////////////////////////////////////////////////////////////////////
// Integer multiply and multiply-accumulate unit of the vector backend.
// One micro-op per cycle in, its result one cycle later.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mac_defines.svh"

module mac_unit
    import mac_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  uop_valid,
    input  funct3_e               funct3,
    input  funct6_e               funct6,
    input  vxrm_e                 vxrm,
    input  eew_e                  eew,
    input  logic [`MAC_ROB_W-1:0] rob_entry,
    input  logic [`MAC_VLEN-1:0]  vs1_data,
    input  logic                  vs1_valid,
    input  logic [`MAC_VLEN-1:0]  vs2_data,
    input  logic                  vs2_valid,
    input  logic [`MAC_VLEN-1:0]  vs3_data,
    input  logic                  vs3_valid,
    input  logic [`MAC_XLEN-1:0]  rs1_data,
    input  logic                  rs1_valid,
    output logic                  w_valid,
    output logic [`MAC_VLEN-1:0]  w_data,
    output logic                  vxsat,
    output logic [`MAC_ROB_W-1:0] w_rob_entry
);

    // issue stage to multiplier array
    logic [`MAC_VLEN-1:0]   src_a;
    logic [`MAC_VLEN-1:0]   src_b;
    logic                   a_signed;
    logic                   b_signed;
    eew_e                   mul_eew;

    // registered, into the result stage
    logic                   stage_valid;
    logic [`MAC_VLEN-1:0]   addend;
    logic                   keep_low;
    logic                   mul_reverse;
    logic                   is_vmac;
    logic                   is_vsmul;
    eew_e                   res_eew;
    vxrm_e                  res_vxrm;
    logic [`MAC_ROB_W-1:0]  res_rob_entry;
    logic [`MAC_PROD_W-1:0] products;

    mac_issue_stage u_issue (.*);

    mac_mul_array u_mul (.*);

    mac_result_stage u_result (.*);

endmodule

`default_nettype wire

/* tests/mac_unit_tb.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the vector multiply-accumulate unit.
// Drives micro-ops on the falling edge and checks each result one
// cycle later against a behavioral model of the element arithmetic.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "mac_defines.svh"

module mac_unit_tb
    import mac_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    // reset check 3, halves 25, accumulate 31, vsmul 25, saturation 4, back-to-back 7
    localparam int TEST_CYCLES  = 3 + 25 + 31 + 25 + 4 + 7;
    localparam int LIMIT_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

    logic                  clk;
    logic                  arst_n;
    logic                  uop_valid;
    funct3_e               funct3;
    funct6_e               funct6;
    vxrm_e                 vxrm;
    eew_e                  eew;
    logic [`MAC_ROB_W-1:0] rob_entry;
    logic [`MAC_VLEN-1:0]  vs1_data;
    logic                  vs1_valid;
    logic [`MAC_VLEN-1:0]  vs2_data;
    logic                  vs2_valid;
    logic [`MAC_VLEN-1:0]  vs3_data;
    logic                  vs3_valid;
    logic [`MAC_XLEN-1:0]  rs1_data;
    logic                  rs1_valid;
    logic                  w_valid;
    logic [`MAC_VLEN-1:0]  w_data;
    logic                  vxsat;
    logic [`MAC_ROB_W-1:0] w_rob_entry;

    // operands of the next micro-op
    logic [`MAC_VLEN-1:0]  op_vs1;
    logic [`MAC_VLEN-1:0]  op_vs2;
    logic [`MAC_VLEN-1:0]  op_vs3;
    logic [`MAC_XLEN-1:0]  op_rs1;
    logic [3:0]            op_src_valid;   // vs1, vs2, vs3, rs1

    logic                  exp_valid;
    logic [`MAC_VLEN-1:0]  exp_data;
    logic                  exp_sat;
    logic [`MAC_ROB_W-1:0] exp_rob;
    logic [`MAC_ROB_W-1:0] next_rob;

    logic [31:0]           lfsr;
    int                    errors;
    int                    checks;
    int                    cycle_cnt;

    mac_unit mac_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == LIMIT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[126:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic randomize_operands();
        op_vs1       = rand_bits(128);
        op_vs2       = rand_bits(128);
        op_vs3       = rand_bits(128);
        op_rs1       = 32'(rand_bits(32));
        op_src_valid = 4'b1111;
    endtask

    //////////////////////////////////////////////////////////////////////
    // behavioral model, one element at a time
    function automatic void model_result(input logic [2:0] f3, input logic [5:0] f6,
                                         input logic [1:0] rm, input logic [2:0] ew_code);
        int           ew;
        int           ne;
        logic         known;
        logic         vv;
        logic         smul;
        logic         sa;
        logic         sb;
        logic         low;
        logic         mac;
        logic         rev;
        logic         swap;
        logic         incr;
        logic [127:0] v1;
        logic [127:0] v2;
        logic [127:0] v3;
        logic [127:0] a_vec;
        logic [127:0] add_vec;
        logic [31:0]  s1;
        logic [63:0]  mask;
        logic [63:0]  ea;
        logic [63:0]  eb;
        logic [63:0]  p;
        logic [63:0]  half;
        logic [63:0]  res;
        longint       sh;
        longint       mx;

        ew    = (ew_code == 3'd1) ? 16 : (ew_code == 3'd2) ? 32 : 8;
        ne    = 128 / ew;
        mask  = (64'd1 << ew) - 1;
        known = (f3 == OPIVV) || (f3 == OPIVX) || (f3 == OPMVV) || (f3 == OPMVX);
        smul  = (f3 == OPIVV) || (f3 == OPIVX);
        vv    = (f3 == OPIVV) || (f3 == OPMVV);
        sa    = 1'b1;
        sb    = 1'b1;
        low   = !smul;
        mac   = 1'b0;
        rev   = 1'b0;
        swap  = 1'b0;
        if (!smul) begin
            case (f6)
                VMULH:   low = 1'b0;
                VMULHU:  {low, sa, sb} = 3'b000;
                VMULHSU: {low, sb} = 2'b00;
                VMACC:   mac = 1'b1;
                VNMSAC:  {mac, rev} = 2'b11;
                VMADD:   {mac, swap} = 2'b11;
                VNMSUB:  {mac, rev, swap} = 3'b111;
                default: low = 1'b1;            // vmul and unknown codes
            endcase
        end
        v1      = op_src_valid[0] ? op_vs1 : '0;
        v2      = op_src_valid[1] ? op_vs2 : '0;
        v3      = op_src_valid[2] ? op_vs3 : '0;
        s1      = op_src_valid[3] ? op_rs1 : '0;
        a_vec   = swap ? v3 : v2;
        add_vec = swap ? v2 : v3;

        exp_valid = known;
        exp_data  = '0;
        exp_sat   = 1'b0;
        for (int e = 0; e < ne; e++) begin
            ea = 64'(a_vec >> (e * ew)) & mask;
            eb = vv ? (64'(v1 >> (e * ew)) & mask) : (64'(s1) & mask);
            if (sa && ea[ew-1]) ea = ea | ~mask;
            if (sb && eb[ew-1]) eb = eb | ~mask;
            p    = ea * eb;
            half = low ? (p & mask) : ((p >> ew) & mask);
            if (smul) begin
                sh = $signed(p) >>> (ew - 1);
                case (rm)
                    2'd0:    incr = p[ew-2];
                    2'd1:    incr = p[ew-2] & ((|(p & ((64'd1 << (ew-2)) - 1))) | p[ew-1]);
                    2'd2:    incr = 1'b0;
                    default: incr = !p[ew-1] && (|(p & ((64'd1 << (ew-1)) - 1)));
                endcase
                sh = sh + longint'(incr);
                mx = (longint'(1) <<< (ew - 1)) - 1;
                if (sh > mx) begin
                    sh      = mx;
                    exp_sat = exp_valid;
                end
                res = 64'(sh) & mask;
            end else if (mac) begin
                res = (64'(add_vec >> (e * ew)) & mask);
                res = (rev ? res - half : res + half) & mask;
            end else begin
                res = half;
            end
            exp_data = exp_data | (128'(res) << (e * ew));
        end
        if (!exp_valid) exp_data = '0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drive and check
    task automatic check_outputs();
        checks++;
        assert (w_valid === exp_valid) else begin
            errors++;
            $display("MISMATCH at %0t: w_valid %b, expected %b", $time, w_valid, exp_valid);
        end
        assert (w_data === exp_data) else begin
            errors++;
            $display("MISMATCH at %0t: w_data %h, expected %h", $time, w_data, exp_data);
        end
        assert (vxsat === exp_sat) else begin
            errors++;
            $display("MISMATCH at %0t: vxsat %b, expected %b", $time, vxsat, exp_sat);
        end
        if (exp_valid) begin
            assert (w_rob_entry === exp_rob) else begin
                errors++;
                $display("MISMATCH at %0t: w_rob_entry %0d, expected %0d",
                         $time, w_rob_entry, exp_rob);
            end
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic apply_uop(input logic [2:0] f3, input logic [5:0] f6,
                             input logic [1:0] rm, input logic [2:0] ew_code);
        uop_valid = 1'b1;
        funct3    = funct3_e'(f3);
        funct6    = f6;
        vxrm      = vxrm_e'(rm);
        eew       = eew_e'(ew_code);
        rob_entry = next_rob;
        vs1_data  = op_vs1;
        vs2_data  = op_vs2;
        vs3_data  = op_vs3;
        rs1_data  = op_rs1;
        {rs1_valid, vs3_valid, vs2_valid, vs1_valid} = op_src_valid;
        model_result(f3, f6, rm, ew_code);
        exp_rob  = next_rob;
        next_rob = next_rob + 1'b1;
        @(posedge clk);
        @(negedge clk);
        uop_valid = 1'b0;
        check_outputs();
    endtask

    task automatic idle_cycle();
        uop_valid = 1'b0;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_sat   = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset_single();
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_sat   = 1'b0;
        check_outputs();                       // reset values, no clock edge yet
        idle_cycle();
        randomize_operands();
        apply_uop(OPMVV, VMUL, RNU, EEW8);
        idle_cycle();                          // exactly one valid
    endtask

    task automatic test_mul_halves();
        logic [5:0] ops [4];
        ops = '{VMUL, VMULH, VMULHU, VMULHSU};
        for (int w = 0; w < 3; w++) begin
            for (int r = 0; r < 2; r++) begin
                for (int k = 0; k < 4; k++) begin
                    randomize_operands();
                    apply_uop(OPMVV, ops[k], RNU, 3'(w));
                end
            end
        end
        idle_cycle();
    endtask

    task automatic test_accumulate();
        logic [5:0] ops [4];
        ops = '{VMACC, VNMSAC, VMADD, VNMSUB};
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < 4; k++) begin
                randomize_operands();
                apply_uop(OPMVV, ops[k], RNU, 3'(w));
                randomize_operands();
                apply_uop(OPMVX, ops[k], RNU, 3'(w));
            end
            // negative scalar, signed and unsigned broadcast
            randomize_operands();
            op_rs1 = op_rs1 | 32'h8080_8080;
            apply_uop(OPMVX, VMULH, RNU, 3'(w));
            apply_uop(OPMVX, VMULHU, RNU, 3'(w));
        end
        idle_cycle();
    endtask

    task automatic test_vsmul_round();
        for (int w = 0; w < 3; w++) begin
            for (int m = 0; m < 4; m++) begin
                randomize_operands();
                apply_uop(OPIVV, VSMUL, 2'(m), 3'(w));
                randomize_operands();
                apply_uop(OPIVX, VSMUL, 2'(m), 3'(w));
            end
        end
        idle_cycle();
    endtask

    task automatic test_vsmul_saturate();
        randomize_operands();
        op_vs1 = {16{8'h80}};
        op_vs2 = op_vs1;
        apply_uop(OPIVV, VSMUL, RNU, EEW8);
        op_vs1 = {8{16'h8000}};
        op_vs2 = op_vs1;
        apply_uop(OPIVV, VSMUL, RNE, EEW16);
        op_vs1 = {4{32'h8000_0000}};
        op_vs2 = op_vs1;
        apply_uop(OPIVV, VSMUL, ROD, EEW32);
        idle_cycle();
    endtask

    task automatic test_back_to_back();
        randomize_operands();
        apply_uop(OPMVV, VMUL, RNU, EEW32);
        op_src_valid = 4'b1110;                // vs1 reads as zero
        apply_uop(OPMVV, VMACC, RNU, EEW16);
        op_src_valid = 4'b1011;                // no addend
        apply_uop(OPMVV, VNMSAC, RNU, EEW8);
        op_src_valid = 4'b0111;                // scalar reads as zero
        apply_uop(OPMVX, VMULH, RNU, EEW32);
        op_src_valid = 4'b1101;
        apply_uop(OPIVV, VSMUL, RNU, EEW16);
        apply_uop(3'b001, VMUL, RNU, EEW8);    // unknown category, no result
        idle_cycle();
    endtask

    initial begin
        arst_n       = 1'b0;
        uop_valid    = 1'b0;
        funct3       = OPMVV;
        funct6       = VMUL;
        vxrm         = RNU;
        eew          = EEW8;
        rob_entry    = '0;
        vs1_data     = '0;
        vs1_valid    = 1'b0;
        vs2_data     = '0;
        vs2_valid    = 1'b0;
        vs3_data     = '0;
        vs3_valid    = 1'b0;
        rs1_data     = '0;
        rs1_valid    = 1'b0;
        lfsr         = 32'h6730_157e;
        next_rob     = '0;
        exp_rob      = '0;
        errors       = 0;
        checks       = 0;
        cycle_cnt    = 0;
        op_src_valid = 4'b1111;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_single();
        test_mul_halves();
        test_accumulate();
        test_vsmul_round();
        test_vsmul_saturate();
        test_back_to_back();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mac_unit.f */
+incdir+logic
logic/mac_pkg.sv
logic/mac_issue_stage.sv
logic/mac_mul_array.sv
logic/mac_result_stage.sv
logic/mac_unit.sv
tests/mac_unit_tb.sv

/* Bender.yml */
package:
  name: mac_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/mac_pkg.sv
      - logic/mac_issue_stage.sv
      - logic/mac_mul_array.sv
      - logic/mac_result_stage.sv
      - logic/mac_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/mac_unit_tb.sv
